//--- bench/ddr_app_model_assert.sv
// protocol checks on the app outputs of the DDR model
// bound into the model from the testbench
module ddr_app_model_assert (
   input logic clk,
   input logic reset,
   input logic init_calib_complete,
   input logic app_rdy,
   input logic app_wdf_rdy,
   input logic app_rd_data_valid,
   input logic app_rd_data_end
);

   // end flag only rides on a valid beat
   end_has_valid: assert property (@(posedge clk) disable iff (reset)
      app_rd_data_end |-> app_rd_data_valid)
      else $error("read end flag seen without valid");

   // low beat always follows a high beat
   end_after_first: assert property (@(posedge clk) disable iff (reset)
      app_rd_data_end |-> $past(app_rd_data_valid && !app_rd_data_end))
      else $error("read end beat not preceded by a first beat");

   // nothing is ready before calibration
   quiet_in_calib: assert property (@(posedge clk) disable iff (reset)
      !init_calib_complete |-> (!app_rdy && !app_wdf_rdy))
      else $error("ready raised before calibration completed");

endmodule

//--- bench/ddr_app_model_tb.sv
// testbench for the DDR app interface memory model
// checks calibration, read timing, random traffic against a reference memory,
// read ordering, read back-pressure and overwrite then read
`include "ddr_app_settings.svh"

module ddr_app_model_tb;

   localparam int clk_period   = 8;
   localparam int idx_w        = $clog2(`DDR_NUM_BANKS * `DDR_BANK_DEPTH);
   localparam int num_bursts   = `DDR_NUM_BANKS * `DDR_BANK_DEPTH;
   localparam int num_rand_ops = 300;
   // random ops plus the directed sections
   localparam int num_ops      = num_rand_ops + 50;
   localparam int limit_cycles = num_ops * 20 + `DDR_CALIB_CYCLES + 2;

   logic                       clk;
   logic                       reset;
   logic [`DDR_ADDR_WIDTH-1:0] app_addr;
   ddr_app_pkg::app_cmd_e      app_cmd;
   logic                       app_en;
   ddr_app_pkg::beat_t         app_wdf_data;
   logic                       app_wdf_end;
   logic                       app_wdf_wren;
   ddr_app_pkg::beat_t         app_rd_data;
   logic                       app_rd_data_end;
   logic                       app_rd_data_valid;
   logic                       app_rdy;
   logic                       app_wdf_rdy;
   logic                       init_calib_complete;

   // reference memory, one burst per burst index
   ddr_app_pkg::burst_u model_mem [num_bursts];
   logic                written [num_bursts];
   // bursts still to come back, in command order
   ddr_app_pkg::burst_u exp_q [$];
   logic                phase_lo;
   logic                rdy_low_seen;
   logic [15:0]         lfsr;

   ddr_app_model dut (
      .clk                 (clk),
      .reset               (reset),
      .init_calib_complete (init_calib_complete),
      .app_addr            (app_addr),
      .app_cmd             (app_cmd),
      .app_en              (app_en),
      .app_wdf_data        (app_wdf_data),
      .app_wdf_end         (app_wdf_end),
      .app_wdf_wren        (app_wdf_wren),
      .app_rd_data         (app_rd_data),
      .app_rd_data_end     (app_rd_data_end),
      .app_rd_data_valid   (app_rd_data_valid),
      .app_rdy             (app_rdy),
      .app_wdf_rdy         (app_wdf_rdy)
   );

   bind ddr_app_model ddr_app_model_assert u_assert (
      .clk                 (clk),
      .reset               (reset),
      .init_calib_complete (init_calib_complete),
      .app_rdy             (app_rdy),
      .app_wdf_rdy         (app_wdf_rdy),
      .app_rd_data_valid   (app_rd_data_valid),
      .app_rd_data_end     (app_rd_data_end)
   );

   always #(clk_period / 2) clk = ~clk;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // byte address of a burst, 8 bytes per burst
   function automatic logic [`DDR_ADDR_WIDTH-1:0] burst_addr(input logic [idx_w-1:0] idx);
      logic [`DDR_ADDR_WIDTH-1:0] a;
      a             = '0;
      a[3 +: idx_w] = idx;
      return a;
   endfunction

   task automatic stop_run();
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic compare_beat(input string name, input ddr_app_pkg::beat_t got,
                               input ddr_app_pkg::beat_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
         stop_run();
      end
   endtask

   // all drivers start and end 1 unit after a rising edge
   task automatic send_cmd(input ddr_app_pkg::app_cmd_e cmd, input logic [idx_w-1:0] idx);
      logic taken;
      app_cmd  = cmd;
      app_addr = burst_addr(idx);
      app_en   = 1'b1;
      taken    = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = app_rdy;
         if (!app_rdy)
            rdy_low_seen = 1'b1;
         @(posedge clk);
         #1;
      end
      app_en = 1'b0;
   endtask

   task automatic drive_beat(input ddr_app_pkg::beat_t data, input logic last);
      logic taken;
      app_wdf_data = data;
      app_wdf_end  = last;
      app_wdf_wren = 1'b1;
      taken        = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = app_wdf_rdy;
         @(posedge clk);
         #1;
      end
      app_wdf_wren = 1'b0;
      app_wdf_end  = 1'b0;
   endtask

   task automatic write_burst(input logic [idx_w-1:0] idx, input ddr_app_pkg::burst_u d);
      drive_beat(d.beats.hi, 1'b0);
      drive_beat(d.beats.lo, 1'b1);
      send_cmd(ddr_app_pkg::APP_CMD_WRITE, idx);
      model_mem[idx] = d;
      written[idx]   = 1'b1;
   endtask

   task automatic read_burst(input logic [idx_w-1:0] idx);
      send_cmd(ddr_app_pkg::APP_CMD_READ, idx);
      exp_q.push_back(model_mem[idx]);
   endtask

   task automatic write_random(input logic [idx_w-1:0] idx);
      ddr_app_pkg::burst_u d;
      d.beats.hi = rand_bits(32);
      d.beats.lo = rand_bits(32);
      write_burst(idx, d);
   endtask

   // returns once every expected burst has come back
   task automatic wait_drain();
      while (exp_q.size() != 0 || phase_lo) begin
         @(posedge clk);
         #1;
      end
   endtask

   // read return monitor, high beat then low beat with end
   always @(negedge clk) begin
      if (!reset) begin
         if (app_rd_data_valid) begin
            if (exp_q.size() == 0) begin
               $display("read data came back at %0t with no read outstanding", $time);
               stop_run();
            end else if (!phase_lo) begin
               compare_flag("app_rd_data_end", app_rd_data_end, 1'b0);
               compare_beat("app_rd_data", app_rd_data, exp_q[0].beats.hi);
               phase_lo = 1'b1;
            end else begin
               compare_flag("app_rd_data_end", app_rd_data_end, 1'b1);
               compare_beat("app_rd_data", app_rd_data, exp_q[0].beats.lo);
               void'(exp_q.pop_front());
               phase_lo = 1'b0;
            end
         end else if (phase_lo) begin
            // low beat must follow right after the high beat
            compare_flag("app_rd_data_valid", app_rd_data_valid, 1'b1);
         end
      end
   end

   initial begin
      #(limit_cycles * clk_period);
      $display("watchdog expired at %0t, the test did not finish", $time);
      stop_run();
   end

   initial begin
      logic [31:0]      r;
      logic [idx_w-1:0] idx;
      clk          = 1'b0;
      reset        = 1'b1;
      app_addr     = '0;
      app_cmd      = ddr_app_pkg::APP_CMD_WRITE;
      app_en       = 1'b0;
      app_wdf_data = '0;
      app_wdf_end  = 1'b0;
      app_wdf_wren = 1'b0;
      phase_lo     = 1'b0;
      rdy_low_seen = 1'b0;
      lfsr         = 16'd84;
      for (int i = 0; i < num_bursts; i++)
         written[i] = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;

      // calibration holds everything low for the fixed delay
      for (int i = 0; i <= `DDR_CALIB_CYCLES; i++) begin
         @(negedge clk);
         compare_flag("init_calib_complete", init_calib_complete, i == `DDR_CALIB_CYCLES);
         compare_flag("app_rdy", app_rdy, i == `DDR_CALIB_CYCLES);
         compare_flag("app_wdf_rdy", app_wdf_rdy, i == `DDR_CALIB_CYCLES);
      end
      @(posedge clk);
      #1;

      // single write then read, fixed return cycles
      write_random(8'd9);
      read_burst(8'd9);
      @(negedge clk);
      compare_flag("app_rd_data_valid", app_rd_data_valid, 1'b0);
      @(negedge clk);
      compare_flag("app_rd_data_valid", app_rd_data_valid, 1'b0);
      @(negedge clk);
      compare_flag("app_rd_data_valid", app_rd_data_valid, 1'b1);
      compare_flag("app_rd_data_end", app_rd_data_end, 1'b0);
      @(negedge clk);
      compare_flag("app_rd_data_valid", app_rd_data_valid, 1'b1);
      compare_flag("app_rd_data_end", app_rd_data_end, 1'b1);
      @(negedge clk);
      compare_flag("app_rd_data_valid", app_rd_data_valid, 1'b0);
      @(posedge clk);
      #1;

      // back to back reads, same bank and mixed banks
      write_random(8'd4);
      write_random(8'd8);
      write_random(8'd1);
      write_random(8'd3);
      write_random(8'd6);
      read_burst(8'd4);
      read_burst(8'd8);
      read_burst(8'd4);
      read_burst(8'd1);
      read_burst(8'd3);
      read_burst(8'd6);
      read_burst(8'd8);
      wait_drain();

      // more reads than slots, ready has to drop and recover
      rdy_low_seen = 1'b0;
      for (int i = 0; i < 2 * `DDR_RD_DEPTH + 2; i++)
         read_burst((i % 2 == 0) ? 8'd8 : 8'd1);
      if (!rdy_low_seen) begin
         $display("app_rdy stayed high through more reads than read slots");
         stop_run();
      end
      wait_drain();
      @(negedge clk);
      compare_flag("app_rdy", app_rdy, 1'b1);
      @(posedge clk);
      #1;

      // overwrite then read on the next accepted cycle
      for (int b = 0; b < `DDR_NUM_BANKS; b++) begin
         idx = idx_w'(b + 20);
         write_random(idx);
         write_random(idx);
         read_burst(idx);
      end
      wait_drain();

      // random traffic over all banks
      for (int i = 0; i < num_rand_ops; i++) begin
         r   = rand_bits(1);
         idx = idx_w'(rand_bits(idx_w));
         if (r[0] && written[idx])
            read_burst(idx);
         else
            write_random(idx);
      end
      wait_drain();

      $display("sim passed");
      $finish;
   end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the DDR app model testbench with Verilator and run it
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
   --top-module ddr_app_model_tb \
   -f src.f

# tee keeps the pipeline status at zero, the log search decides
./obj_dir/Vddr_app_model_tb 2>&1 | tee sim.log

if grep -qx "sim passed" sim.log; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi

//--- source/app_bank.sv
// one storage bank of the app model
// a write stores on the request edge, a read is registered for one cycle
// and then queued until the read sequencer pops it
`include "ddr_app_settings.svh"

module app_bank (
   input  logic                   clk,
   input  logic                   reset,
   input  ddr_app_pkg::bank_req_t req,
   input  logic                   pop,
   output ddr_app_pkg::rd_word_t  head
);

   localparam int QW = $clog2(`DDR_RD_DEPTH);

   ddr_app_pkg::burst_u mem [`DDR_BANK_DEPTH];
   ddr_app_pkg::burst_u rd_word;
   logic                rd_pend;
   ddr_app_pkg::burst_u q [`DDR_RD_DEPTH];
   logic [QW-1:0]       wr_ptr;
   logic [QW-1:0]       rd_ptr;
   logic [QW:0]         q_cnt;

   // storage and registered read
   always_ff @(posedge clk) begin
      if (req.wr_en)
         mem[req.idx] <= req.data;
      if (req.rd_en)
         rd_word <= mem[req.idx];
   end

   // queue payload
   always_ff @(posedge clk) begin
      if (rd_pend)
         q[wr_ptr] <= rd_word;
   end

   // queue control, router keeps reads in flight below the depth
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_pend <= 1'b0;
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         q_cnt   <= '0;
      end else begin
         rd_pend <= req.rd_en;
         if (rd_pend)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (rd_pend && !pop)
            q_cnt <= q_cnt + 1'b1;
         else if (pop && !rd_pend)
            q_cnt <= q_cnt - 1'b1;
      end
   end

   assign head.valid = (q_cnt != '0);
   assign head.data  = q[rd_ptr];

endmodule

//--- source/app_cmd_router.sv
// command side of the app model
// holds off everything until calibration, collects the two write beats,
// accepts commands and turns each one into a request for a single bank
`include "ddr_app_settings.svh"

module app_cmd_router (
   input  logic                                        clk,
   input  logic                                        reset,
   input  logic [`DDR_ADDR_WIDTH-1:0]                  app_addr,
   input  ddr_app_pkg::app_cmd_e                       app_cmd,
   input  logic                                        app_en,
   input  ddr_app_pkg::beat_t                          app_wdf_data,
   input  logic                                        app_wdf_wren,
   input  logic                                        app_wdf_end,
   input  logic                                        slot_free,
   output logic                                        app_rdy,
   output logic                                        app_wdf_rdy,
   output logic                                        init_calib_complete,
   output ddr_app_pkg::bank_req_t [`DDR_NUM_BANKS-1:0] bank_req,
   output logic                                        rd_push,
   output ddr_app_pkg::bank_id_t                       rd_tag
);

   localparam int CAL_W  = $clog2(`DDR_CALIB_CYCLES) + 1;
   localparam int BANK_W = $bits(ddr_app_pkg::bank_id_t);
   localparam int WORD_W = $bits(ddr_app_pkg::word_idx_t);

   logic [CAL_W-1:0]           cal_cnt;
   ddr_app_pkg::burst_u        wr_burst;
   logic                       have_hi;
   logic                       burst_full;
   logic [`DDR_ADDR_WIDTH-4:0] burst_idx;
   ddr_app_pkg::bank_id_t      bank_sel;
   ddr_app_pkg::word_idx_t     word_sel;
   logic                       beat_fire;
   logic                       cmd_fire;
   logic                       wr_fire;
   logic                       rd_fire;

   // calibration delay after reset
   always_ff @(posedge clk) begin
      if (reset) begin
         cal_cnt             <= '0;
         init_calib_complete <= 1'b0;
      end else if (!init_calib_complete) begin
         cal_cnt <= cal_cnt + 1'b1;
         if (cal_cnt == CAL_W'(`DDR_CALIB_CYCLES - 1))
            init_calib_complete <= 1'b1;
      end
   end

   // ready only after calibration, read slots bound the command side
   assign app_rdy     = init_calib_complete && slot_free;
   // data channel stalls while a full burst waits for its command
   assign app_wdf_rdy = init_calib_complete && !burst_full;

   assign beat_fire = app_wdf_wren && app_wdf_rdy;
   assign cmd_fire  = app_en && app_rdy;
   // write without a complete burst is dropped
   assign wr_fire   = cmd_fire && (app_cmd == ddr_app_pkg::APP_CMD_WRITE) && burst_full;
   assign rd_fire   = cmd_fire && (app_cmd == ddr_app_pkg::APP_CMD_READ);

   // beat collection, high half first, end beat is the low half
   always_ff @(posedge clk) begin
      if (beat_fire) begin
         if (app_wdf_end)
            wr_burst.beats.lo <= app_wdf_data;
         else
            wr_burst.beats.hi <= app_wdf_data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         have_hi    <= 1'b0;
         burst_full <= 1'b0;
      end else begin
         if (beat_fire) begin
            have_hi    <= !app_wdf_end;
            burst_full <= app_wdf_end && have_hi;
         end else if (wr_fire) begin
            burst_full <= 1'b0;
         end
      end
   end

   // burst index is the address over 8, low bits pick the bank
   assign burst_idx = app_addr[`DDR_ADDR_WIDTH-1:3];
   assign bank_sel  = burst_idx[BANK_W-1:0];
   assign word_sel  = burst_idx[BANK_W +: WORD_W];

   always_comb begin
      for (int b = 0; b < `DDR_NUM_BANKS; b++) begin
         bank_req[b].wr_en = wr_fire && (bank_sel == BANK_W'(b));
         bank_req[b].rd_en = rd_fire && (bank_sel == BANK_W'(b));
         bank_req[b].idx   = word_sel;
         bank_req[b].data  = wr_burst;
      end
   end

   // sequencer learns the return order from here
   assign rd_push = rd_fire;
   assign rd_tag  = bank_sel;

endmodule

//--- source/app_rd_sequencer.sv
// read return side of the app model
// keeps bank tags in command order, waits for the named bank's head and
// sends it as two beats, high then low, end flag on the low beat
`include "ddr_app_settings.svh"

module app_rd_sequencer (
   input  logic                                       clk,
   input  logic                                       reset,
   input  logic                                       rd_push,
   input  ddr_app_pkg::bank_id_t                      rd_tag,
   input  ddr_app_pkg::rd_word_t [`DDR_NUM_BANKS-1:0] heads,
   output logic [`DDR_NUM_BANKS-1:0]                  pops,
   output logic                                       slot_free,
   output ddr_app_pkg::beat_t                         app_rd_data,
   output logic                                       app_rd_data_valid,
   output logic                                       app_rd_data_end
);

   localparam int TAG_W = $clog2(`DDR_RD_DEPTH);

   ddr_app_pkg::bank_id_t tags [`DDR_RD_DEPTH];
   logic [TAG_W-1:0]      tag_wr;
   logic [TAG_W-1:0]      tag_rd;
   logic [TAG_W:0]        tag_cnt;
   ddr_app_pkg::bank_id_t cur_tag;
   ddr_app_pkg::rd_word_t cur_head;
   logic                  second_beat;
   logic                  start;

   // oldest outstanding read and the head of its bank
   assign cur_tag  = tags[tag_rd];
   assign cur_head = heads[cur_tag];

   // first beat once the data has reached the bank queue
   assign start = !second_beat && (tag_cnt != '0) && cur_head.valid;

   // a slot counts as busy until its low beat goes out
   assign slot_free = (tag_cnt < (TAG_W + 1)'(`DDR_RD_DEPTH));

   // pop the bank on the low beat, head stays valid until then
   always_comb begin
      pops = '0;
      if (second_beat)
         pops[cur_tag] = 1'b1;
   end

   always_ff @(posedge clk) begin
      if (rd_push)
         tags[tag_wr] <= rd_tag;
   end

   always_ff @(posedge clk) begin
      if (start)
         app_rd_data <= cur_head.data.beats.hi;
      else if (second_beat)
         app_rd_data <= cur_head.data.beats.lo;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         tag_wr            <= '0;
         tag_rd            <= '0;
         tag_cnt           <= '0;
         second_beat       <= 1'b0;
         app_rd_data_valid <= 1'b0;
         app_rd_data_end   <= 1'b0;
      end else begin
         if (rd_push)
            tag_wr <= tag_wr + 1'b1;
         if (second_beat)
            tag_rd <= tag_rd + 1'b1;
         // push and retire in one cycle leave the count alone
         if (rd_push && !second_beat)
            tag_cnt <= tag_cnt + 1'b1;
         else if (second_beat && !rd_push)
            tag_cnt <= tag_cnt - 1'b1;
         second_beat       <= start;
         app_rd_data_valid <= start || second_beat;
         app_rd_data_end   <= second_beat;
      end
   end

endmodule

//--- source/ddr_app_model.sv
// synthesizable stand-in for a DDR controller's user-side app interface
// drop in where the vendor controller sits, same handshake and beat order
// router feeds the banks, sequencer returns reads in command order
`include "ddr_app_settings.svh"

module ddr_app_model (
   input  logic                       clk,
   input  logic                       reset,
   output logic                       init_calib_complete,
   input  logic [`DDR_ADDR_WIDTH-1:0] app_addr,
   input  ddr_app_pkg::app_cmd_e      app_cmd,
   input  logic                       app_en,
   input  ddr_app_pkg::beat_t         app_wdf_data,
   input  logic                       app_wdf_end,
   input  logic                       app_wdf_wren,
   output ddr_app_pkg::beat_t         app_rd_data,
   output logic                       app_rd_data_end,
   output logic                       app_rd_data_valid,
   output logic                       app_rdy,
   output logic                       app_wdf_rdy
);

   ddr_app_pkg::bank_req_t [`DDR_NUM_BANKS-1:0] bank_req;
   ddr_app_pkg::rd_word_t [`DDR_NUM_BANKS-1:0]  heads;
   logic [`DDR_NUM_BANKS-1:0]                   pops;
   logic                                        slot_free;
   logic                                        rd_push;
   ddr_app_pkg::bank_id_t                       rd_tag;

   app_cmd_router u_router (
      .clk                 (clk),
      .reset               (reset),
      .app_addr            (app_addr),
      .app_cmd             (app_cmd),
      .app_en              (app_en),
      .app_wdf_data        (app_wdf_data),
      .app_wdf_wren        (app_wdf_wren),
      .app_wdf_end         (app_wdf_end),
      .slot_free           (slot_free),
      .app_rdy             (app_rdy),
      .app_wdf_rdy         (app_wdf_rdy),
      .init_calib_complete (init_calib_complete),
      .bank_req            (bank_req),
      .rd_push             (rd_push),
      .rd_tag              (rd_tag)
   );

   // one bank per low burst index value
   for (genvar b = 0; b < `DDR_NUM_BANKS; b++) begin : g_bank
      app_bank u_bank (
         .clk   (clk),
         .reset (reset),
         .req   (bank_req[b]),
         .pop   (pops[b]),
         .head  (heads[b])
      );
   end

   app_rd_sequencer u_rd_seq (
      .clk               (clk),
      .reset             (reset),
      .rd_push           (rd_push),
      .rd_tag            (rd_tag),
      .heads             (heads),
      .pops              (pops),
      .slot_free         (slot_free),
      .app_rd_data       (app_rd_data),
      .app_rd_data_valid (app_rd_data_valid),
      .app_rd_data_end   (app_rd_data_end)
   );

endmodule

//--- source/ddr_app_pkg.sv
// shared types for the DDR app interface memory model
// command codes, the 64-bit burst and the router/bank/sequencer structs
`include "ddr_app_settings.svh"

package ddr_app_pkg;

   // only write and read are modelled
   typedef enum logic [2:0] {
      APP_CMD_WRITE = 3'b000,
      APP_CMD_READ  = 3'b001
   } app_cmd_e;

   // one beat on the data channels
   typedef logic [`DDR_DATA_WIDTH-1:0] beat_t;

   // high beat travels first on both channels
   typedef struct packed {
      beat_t hi;
      beat_t lo;
   } beat_pair_t;

   // whole word for storage, beat pair for the transfers
   typedef union packed {
      logic [2*`DDR_DATA_WIDTH-1:0] word;
      beat_pair_t                   beats;
   } burst_u;

   typedef logic [$clog2(`DDR_NUM_BANKS)-1:0] bank_id_t;
   typedef logic [$clog2(`DDR_BANK_DEPTH)-1:0] word_idx_t;

   // router to bank, at most one bank has an enable set
   typedef struct packed {
      logic      wr_en;
      logic      rd_en;
      word_idx_t idx;
      burst_u    data;
   } bank_req_t;

   // head of a bank output queue
   typedef struct packed {
      logic   valid;
      burst_u data;
   } rd_word_t;

endpackage

//--- source/ddr_app_settings.svh
// sizing for the DDR app interface memory model
// included by the package and by every RTL file that needs a size
// DDR_RD_DEPTH must be a power of two, the read queues wrap their pointers
`ifndef DDR_APP_SETTINGS_SVH
`define DDR_APP_SETTINGS_SVH

// one data beat on the app bus
`define DDR_DATA_WIDTH 32

// app address, byte addressed, one burst per 8 addresses
`define DDR_ADDR_WIDTH 30

// storage banks, picked by the low bits of the burst index
`define DDR_NUM_BANKS 4

// bursts held in each bank
`define DDR_BANK_DEPTH 64

// most reads in flight at once
`define DDR_RD_DEPTH 4

// cycles from reset release until calibration completes
`define DDR_CALIB_CYCLES 16

`endif

//--- src.f
+incdir+source
source/ddr_app_pkg.sv
source/app_cmd_router.sv
source/app_bank.sv
source/app_rd_sequencer.sv
source/ddr_app_model.sv
bench/ddr_app_model_assert.sv
bench/ddr_app_model_tb.sv
